/* etrace.f */
+incdir+hdl
+incdir+verif
hdl/etrace_pkg.sv
hdl/etrace_cfg_regs.sv
hdl/etrace_sampler.sv
hdl/etrace_fifo.sv
hdl/etrace_packer.sv
hdl/etrace.sv
verif/etrace_tb.sv

/* hdl/etrace.sv */
`timescale 1ns/1ps
`include "etrace_config.svh"

module etrace
   import etrace_pkg::*;
(
   input  logic                  trace_clk,
   input  logic                  nreset,
   input  logic                  trace_trigger,
   input  logic [`ETRACE_VW-1:0] trace_vector,
   input  logic                  cfg_access_in,
   input  emesh_packet_t         cfg_packet_in,
   output logic                  cfg_access_out,
   output emesh_packet_t         cfg_packet_out,
   output logic                  data_access_out,
   output emesh_packet_t         data_packet_out
);

   logic                  trace_en;
   logic                  loop_en;
   logic [3:0]            samplerate;
   logic [`ETRACE_AW-1:0] base_addr;
   logic                  push;
   trace_rec_t            rec;
   logic                  pop;
   logic                  empty;
   trace_rec_t            head;
   logic                  overflow_set;

   // ########################################
   // Config registers
   // ########################################

   etrace_cfg_regs i_cfg_regs (
      .trace_clk      (trace_clk),
      .nreset         (nreset),
      .cfg_access_in  (cfg_access_in),
      .cfg_packet_in  (cfg_packet_in),
      .overflow_set   (overflow_set),
      .cfg_access_out (cfg_access_out),
      .cfg_packet_out (cfg_packet_out),
      .trace_en       (trace_en),
      .loop_en        (loop_en),
      .samplerate     (samplerate),
      .base_addr      (base_addr)
   );

   // ########################################
   // Capture path
   // ########################################

   etrace_sampler i_sampler (
      .trace_clk     (trace_clk),
      .nreset        (nreset),
      .trace_trigger (trace_trigger),
      .trace_vector  (trace_vector),
      .trace_en      (trace_en),
      .loop_en       (loop_en),
      .samplerate    (samplerate),
      .push          (push),
      .rec           (rec)
   );

   // Record buffer between sampler and packer
   etrace_fifo i_fifo (
      .trace_clk    (trace_clk),
      .nreset       (nreset),
      .push         (push),
      .rec          (rec),
      .pop          (pop),
      .head         (head),
      .empty        (empty),
      .overflow_set (overflow_set)
   );

   etrace_packer i_packer (
      .trace_clk       (trace_clk),
      .nreset          (nreset),
      .empty           (empty),
      .head            (head),
      .base_addr       (base_addr),
      .pop             (pop),
      .data_access_out (data_access_out),
      .data_packet_out (data_packet_out)
   );

endmodule

/* hdl/etrace_cfg_regs.sv */
`timescale 1ns/1ps
`include "etrace_config.svh"

module etrace_cfg_regs
   import etrace_pkg::*;
(
   input  logic                  trace_clk,
   input  logic                  nreset,
   input  logic                  cfg_access_in,
   input  emesh_packet_t         cfg_packet_in,
   input  logic                  overflow_set,
   output logic                  cfg_access_out,
   output emesh_packet_t         cfg_packet_out,
   output logic                  trace_en,
   output logic                  loop_en,
   output logic [3:0]            samplerate,
   output logic [`ETRACE_AW-1:0] base_addr
);

   logic          hit;
   logic          wr_req;
   logic          rd_req;
   logic [3:0]    reg_idx;
   cfg_word_u     wr_word;
   cfg_word_u     rd_word;
   logic          overflow;
   emesh_packet_t resp;

   // ########################################
   // Decode
   // ########################################

   // ID and group must both match
   assign hit = cfg_access_in &
                (cfg_packet_in.dstaddr[31:20] == `ETRACE_ID) &
                (cfg_packet_in.dstaddr[19:16] == `ETRACE_REGS);

   assign reg_idx = cfg_packet_in.dstaddr[5:2];
   assign wr_req  = hit & cfg_packet_in.write;
   assign rd_req  = hit & ~cfg_packet_in.write;

   // Incoming data word, viewed per register
   assign wr_word = cfg_packet_in.data;

   // ########################################
   // Registers
   // ########################################

   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
      begin
         trace_en   <= 1'b0;
         loop_en    <= 1'b0;
         samplerate <= 4'd0;
         base_addr  <= '0;
      end
      else
      begin
         if (wr_req && (reg_idx == `ETRACE_CFG))
         begin
            trace_en   <= wr_word.cfg.trace_en;
            loop_en    <= wr_word.cfg.loop_en;
            samplerate <= wr_word.cfg.samplerate;
         end
         if (wr_req && (reg_idx == `ETRACE_BASE))
            base_addr <= wr_word.base;
      end
   end

   // Sticky overflow where a new drop wins over the clearing write
   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
         overflow <= 1'b0;
      else if (overflow_set)
         overflow <= 1'b1;
      else if (wr_req && (reg_idx == `ETRACE_CFG))
         overflow <= 1'b0;
   end

   // ########################################
   // Readback
   // ########################################

   // Register value in the matching view
   always_comb
   begin
      rd_word = '0;
      if (reg_idx == `ETRACE_CFG)
      begin
         rd_word.cfg.overflow   = overflow;
         rd_word.cfg.samplerate = samplerate;
         rd_word.cfg.loop_en    = loop_en;
         rd_word.cfg.trace_en   = trace_en;
      end
      else if (reg_idx == `ETRACE_BASE)
         rd_word.base = base_addr;
   end

   // Response goes back to the requester with addresses swapped
   always_comb
   begin
      resp          = '0;
      resp.write    = 1'b1;
      resp.datamode = `ETRACE_DM32;
      resp.ctrlmode = cfg_packet_in.ctrlmode;
      resp.dstaddr  = cfg_packet_in.srcaddr;
      resp.data     = rd_word;
      resp.srcaddr  = cfg_packet_in.dstaddr;
   end

   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
      begin
         cfg_access_out <= 1'b0;
         cfg_packet_out <= '0;
      end
      else
      begin
         cfg_access_out <= rd_req;
         if (rd_req)
            cfg_packet_out <= resp;
      end
   end

   // A response only follows a read request and carries this unit's ID back
   a_resp_src : assert property (@(posedge trace_clk) disable iff (!nreset)
      cfg_access_out |-> $past(cfg_access_in && !cfg_packet_in.write) &&
                         (cfg_packet_out.srcaddr[31:20] == `ETRACE_ID));

endmodule

/* hdl/etrace_config.svh */
`ifndef ETRACE_CONFIG_SVH
`define ETRACE_CONFIG_SVH

// ########################################
// Mesh addressing
// ########################################

// Mesh ID, matched on dstaddr[31:20]
`define ETRACE_ID      12'h3e7

// Register group, matched on dstaddr[19:16]
`define ETRACE_REGS    4'h0

// Register indices on dstaddr[5:2]
`define ETRACE_CFG     4'h0
`define ETRACE_BASE    4'h1

// ########################################
// Sizes
// ########################################

// Samples per non-loop run, also FIFO depth
`define ETRACE_DEPTH   16
`define ETRACE_PTRW    4

// Vector, timestamp, index and address widths
`define ETRACE_VW      32
`define ETRACE_DW      32
`define ETRACE_IW      8
`define ETRACE_AW      32

// Mesh datamode codes
`define ETRACE_DM32    2'b10
`define ETRACE_DM64    2'b11

`endif

/* hdl/etrace_fifo.sv */
`timescale 1ns/1ps
`include "etrace_config.svh"

module etrace_fifo
   import etrace_pkg::*;
(
   input  logic       trace_clk,
   input  logic       nreset,
   input  logic       push,
   input  trace_rec_t rec,
   input  logic       pop,
   output trace_rec_t head,
   output logic       empty,
   output logic       overflow_set
);

   trace_rec_t              mem [`ETRACE_DEPTH];
   logic [`ETRACE_PTRW-1:0] wr_ptr;
   logic [`ETRACE_PTRW-1:0] rd_ptr;
   logic [`ETRACE_PTRW:0]   count;
   logic                    full;
   logic                    wr_en;

   // ########################################
   // Flags
   // ########################################

   assign full  = (count == (`ETRACE_PTRW+1)'(`ETRACE_DEPTH));
   assign empty = (count == '0);

   // Push into a full buffer is dropped
   assign wr_en        = push & ~full;
   assign overflow_set = push & full;

   // ########################################
   // Storage
   // ########################################

   always_ff @(posedge trace_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= rec;
   end

   // Show-ahead, oldest entry always on head
   assign head = mem[rd_ptr];

   // ########################################
   // Pointers and count
   // ########################################

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
         count <= '0;
      else if (wr_en && !pop)
         count <= count + 1'b1;
      else if (pop && !wr_en)
         count <= count - 1'b1;
   end

   // Reader never underruns
   a_no_pop_empty : assert property (@(posedge trace_clk) disable iff (!nreset)
      pop |-> !empty);

   // Occupancy bound
   a_count_max : assert property (@(posedge trace_clk) disable iff (!nreset)
      count <= (`ETRACE_PTRW+1)'(`ETRACE_DEPTH));

endmodule

/* hdl/etrace_packer.sv */
`timescale 1ns/1ps
`include "etrace_config.svh"

module etrace_packer
   import etrace_pkg::*;
(
   input  logic                  trace_clk,
   input  logic                  nreset,
   input  logic                  empty,
   input  trace_rec_t            head,
   input  logic [`ETRACE_AW-1:0] base_addr,
   output logic                  pop,
   output logic                  data_access_out,
   output emesh_packet_t         data_packet_out
);

   logic [`ETRACE_AW-1:0] offset;
   emesh_packet_t         pkt;

   // ########################################
   // Pop
   // ########################################

   // No back-pressure so drain whenever data waits
   assign pop = ~empty;

   // ########################################
   // Packet build
   // ########################################

   // Eight bytes per slot
   assign offset = {{(`ETRACE_AW - `ETRACE_IW - 3){1'b0}}, head.index, 3'b000};

   always_comb
   begin
      pkt          = '0;
      pkt.write    = 1'b1;
      pkt.datamode = `ETRACE_DM64;
      pkt.dstaddr  = base_addr + offset;
      pkt.data     = head.vector;
      // Timestamp rides in srcaddr
      pkt.srcaddr  = head.stamp;
   end

   // ########################################
   // Output stage
   // ########################################

   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
      begin
         data_access_out <= 1'b0;
         data_packet_out <= '0;
      end
      else
      begin
         data_access_out <= pop;
         if (pop)
            data_packet_out <= pkt;
      end
   end

   // Each output packet lands inside the destination window
   a_out_window : assert property (@(posedge trace_clk) disable iff (!nreset)
      data_access_out |->
         ((data_packet_out.dstaddr - $past(base_addr)) < `ETRACE_AW'(`ETRACE_DEPTH * 8)));

endmodule

/* hdl/etrace_pkg.sv */
`include "etrace_config.svh"

package etrace_pkg;

   // ########################################
   // Mesh packet
   // ########################################

   // 104 bit mesh packet, MSB first
   typedef struct packed
   {
      logic                  pad;
      logic                  write;
      logic [1:0]            datamode;
      logic [3:0]            ctrlmode;
      logic [`ETRACE_AW-1:0] dstaddr;
      logic [31:0]           data;
      logic [`ETRACE_AW-1:0] srcaddr;
   } emesh_packet_t;

   // ########################################
   // Trace record
   // ########################################

   // One captured sample as held in the FIFO
   typedef struct packed
   {
      logic [`ETRACE_VW-1:0] vector;
      logic [`ETRACE_DW-1:0] stamp;
      logic [`ETRACE_IW-1:0] index;
   } trace_rec_t;

   // ########################################
   // Config register word
   // ########################################

   // CFG register layout
   typedef struct packed
   {
      logic [22:0] unused;
      logic        overflow;
      logic [3:0]  samplerate;
      logic [1:0]  reserved;
      logic        loop_en;
      logic        trace_en;
   } cfg_bits_t;

   // Packet data word, view picked by register index
   typedef union packed
   {
      cfg_bits_t   cfg;
      logic [31:0] base;
   } cfg_word_u;

endpackage

/* hdl/etrace_sampler.sv */
`timescale 1ns/1ps
`include "etrace_config.svh"

module etrace_sampler
   import etrace_pkg::*;
(
   input  logic                  trace_clk,
   input  logic                  nreset,
   input  logic                  trace_trigger,
   input  logic [`ETRACE_VW-1:0] trace_vector,
   input  logic                  trace_en,
   input  logic                  loop_en,
   input  logic [3:0]            samplerate,
   output logic                  push,
   output trace_rec_t            rec
);

   logic [`ETRACE_VW-1:0] vec_q;
   logic [`ETRACE_DW-1:0] stamp;
   logic [15:0]           div_cnt;
   logic [15:0]           rate_mask;
   logic                  tick;
   logic                  change;
   logic                  sample;
   logic [`ETRACE_IW-1:0] idx;
   logic                  last_idx;
   logic                  stop;

   // ########################################
   // Time keeper
   // ########################################

   // Trigger cycles since enable
   always_ff @(posedge trace_clk)
   begin
      if (!nreset || !trace_en)
         stamp <= '0;
      else if (trace_trigger)
         stamp <= stamp + 1'b1;
   end

   // Rate divider free running on trigger cycles
   always_ff @(posedge trace_clk)
   begin
      if (!nreset || !trace_en)
         div_cnt <= '0;
      else if (trace_trigger)
         div_cnt <= div_cnt + 1'b1;
   end

   // Tick once every 2^samplerate trigger cycles
   assign rate_mask = (16'd1 << samplerate) - 16'd1;
   assign tick      = ((div_cnt & rate_mask) == 16'd0);

   // ########################################
   // Sample qualify
   // ########################################

   // Previous vector updated every cycle
   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
         vec_q <= '0;
      else
         vec_q <= trace_vector;
   end

   assign change = |(vec_q ^ trace_vector);
   assign sample = trace_en & trace_trigger & change & tick & ~stop;

   // ########################################
   // Index and stop
   // ########################################

   assign last_idx = (idx == `ETRACE_IW'(`ETRACE_DEPTH - 1));

   // Index wraps at depth
   always_ff @(posedge trace_clk)
   begin
      if (!nreset || !trace_en)
         idx <= '0;
      else if (sample)
         idx <= last_idx ? '0 : idx + 1'b1;
   end

   // Non-loop run ends after the last slot
   always_ff @(posedge trace_clk)
   begin
      if (!nreset || !trace_en)
         stop <= 1'b0;
      else if (sample && last_idx && !loop_en)
         stop <= 1'b1;
   end

   // Capture record pushed one cycle after the sample
   always_ff @(posedge trace_clk)
   begin
      if (!nreset)
      begin
         push <= 1'b0;
         rec  <= '0;
      end
      else
      begin
         push <= sample;
         if (sample)
         begin
            rec.vector <= trace_vector;
            rec.stamp  <= stamp;
            rec.index  <= idx;
         end
      end
   end

   // Slot in range and never ahead of the timestamp
   a_rec_index : assert property (@(posedge trace_clk) disable iff (!nreset)
      push |-> (rec.index < `ETRACE_IW'(`ETRACE_DEPTH)) &&
               (rec.stamp >= `ETRACE_DW'(rec.index)));

endmodule

/* verif/etrace_stim_table.svh */
`ifndef ETRACE_STIM_TABLE_SVH
`define ETRACE_STIM_TABLE_SVH

// Columns: op, mesh ID, register index, write data, trigger, random vector flag,
// fixed vector, expected read data, number of cycles the row is held

localparam int          NUM_ROWS = 27;
localparam logic [11:0] ID_OK    = `ETRACE_ID;
localparam logic [11:0] ID_BAD   = 12'h3e6;
localparam logic [3:0]  R_CFG    = `ETRACE_CFG;
localparam logic [3:0]  R_BASE   = `ETRACE_BASE;

stim_row_t stim [NUM_ROWS];

task automatic load_table();
   // ########################################
   // Register access
   // ########################################
   stim[0]  = '{OP_WR,   ID_OK,  R_BASE, 32'h40001000, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[1]  = '{OP_RD,   ID_OK,  R_BASE, 32'h0, 1'b0, 1'b0, 32'h0, 32'h40001000, 1};
   stim[2]  = '{OP_WR,   ID_OK,  R_CFG,  32'h00000002, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[3]  = '{OP_RD,   ID_OK,  R_CFG,  32'h0, 1'b0, 1'b0, 32'h0, 32'h00000002, 1};
   // Foreign ID, no response and no write
   stim[4]  = '{OP_RD,   ID_BAD, R_CFG,  32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[5]  = '{OP_WR,   ID_BAD, R_BASE, 32'hdeadbeef, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[6]  = '{OP_RD,   ID_OK,  R_BASE, 32'h0, 1'b0, 1'b0, 32'h0, 32'h40001000, 1};
   // ########################################
   // Rate 0, single run
   // ########################################
   stim[7]  = '{OP_WR,   ID_OK,  R_CFG,  32'h00000001, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[8]  = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b1, 1'b1, 32'h0, 32'h0, 4};
   // No trigger, then a held vector
   stim[9]  = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b0, 1'b1, 32'h0, 32'h0, 3};
   stim[10] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b1, 1'b0, 32'h00005a5a, 32'h0, 3};
   stim[11] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b0, 1'b0, 32'h00005a5a, 32'h0, 2};
   // Runs past the depth, stops at 16 samples
   stim[12] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b1, 1'b1, 32'h0, 32'h0, 14};
   stim[13] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 4};
   stim[14] = '{OP_RD,   ID_OK,  R_CFG,  32'h0, 1'b0, 1'b0, 32'h0, 32'h00000001, 1};
   // ########################################
   // Restart at rate 2
   // ########################################
   stim[15] = '{OP_WR,   ID_OK,  R_CFG,  32'h00000000, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[16] = '{OP_WR,   ID_OK,  R_CFG,  32'h00000021, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[17] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b1, 1'b1, 32'h0, 32'h0, 12};
   stim[18] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 3};
   stim[19] = '{OP_RD,   ID_OK,  R_CFG,  32'h0, 1'b0, 1'b0, 32'h0, 32'h00000021, 1};
   // Loop mode, index wraps past 15
   stim[20] = '{OP_WR,   ID_OK,  R_CFG,  32'h00000000, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[21] = '{OP_WR,   ID_OK,  R_BASE, 32'h40002000, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[22] = '{OP_WR,   ID_OK,  R_CFG,  32'h00000003, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[23] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b1, 1'b1, 32'h0, 32'h0, 20};
   stim[24] = '{OP_RD,   ID_OK,  R_BASE, 32'h0, 1'b0, 1'b0, 32'h0, 32'h40002000, 1};
   stim[25] = '{OP_WR,   ID_OK,  R_CFG,  32'h00000000, 1'b0, 1'b0, 32'h0, 32'h0, 1};
   stim[26] = '{OP_NONE, ID_OK,  R_CFG,  32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 6};
endtask

`endif

/* verif/etrace_tb.sv */
`timescale 1ns/1ps
`include "etrace_config.svh"

module etrace_tb
   import etrace_pkg::*;
();

   localparam int OP_NONE     = 0;
   localparam int OP_WR       = 1;
   localparam int OP_RD       = 2;
   localparam int DRAIN_LIMIT = 40;

   // One table row
   typedef struct {
      int          op;
      logic [11:0] id;
      logic [3:0]  idx;
      logic [31:0] data;
      logic        trig;
      logic        rnd;
      logic [31:0] vec;
      logic [31:0] exp_rd;
      int          reps;
   } stim_row_t;

   // Expected data packet and the cycle it shows up
   typedef struct {
      emesh_packet_t pkt;
      int            due;
   } exp_pkt_t;

   `include "etrace_stim_table.svh"

   logic          trace_clk;
   logic          nreset;
   logic          trace_trigger;
   logic [31:0]   trace_vector;
   logic          cfg_access_in;
   emesh_packet_t cfg_packet_in;
   logic          cfg_access_out;
   emesh_packet_t cfg_packet_out;
   logic          data_access_out;
   emesh_packet_t data_packet_out;

   // Reference model state
   logic          m_en;
   logic          m_loop;
   logic [3:0]    m_rate;
   logic [31:0]   m_base;
   logic [31:0]   m_stamp;
   logic [15:0]   m_div;
   int            m_idx;
   logic          m_stop;
   logic [31:0]   m_prev;
   exp_pkt_t      exp_q [$];
   logic          rd_pending;
   emesh_packet_t rd_exp;
   int            cyc;

   etrace i_etrace (
      .trace_clk       (trace_clk),
      .nreset          (nreset),
      .trace_trigger   (trace_trigger),
      .trace_vector    (trace_vector),
      .cfg_access_in   (cfg_access_in),
      .cfg_packet_in   (cfg_packet_in),
      .cfg_access_out  (cfg_access_out),
      .cfg_packet_out  (cfg_packet_out),
      .data_access_out (data_access_out),
      .data_packet_out (data_packet_out)
   );

   // 40 ns period
   initial trace_clk = 1'b0;
   always #20 trace_clk = ~trace_clk;

   // ########################################
   // Checking
   // ########################################

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "Stopping on first error");
   endtask

   task automatic compare_hex(input string name, input logic [103:0] got,
                              input logic [103:0] exp);
      assert (got === exp)
      else
         fail_run($sformatf("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got));
   endtask

   // Outputs sampled on the falling edge while stable
   task automatic check_outputs();
      exp_pkt_t e;
      // Read response due one cycle after the request
      compare_hex("cfg_access_out", cfg_access_out, rd_pending);
      if (rd_pending)
      begin
         compare_hex("cfg_packet_out.write", cfg_packet_out.write, rd_exp.write);
         compare_hex("cfg_packet_out.dstaddr", cfg_packet_out.dstaddr, rd_exp.dstaddr);
         compare_hex("cfg_packet_out.srcaddr", cfg_packet_out.srcaddr, rd_exp.srcaddr);
         compare_hex("cfg_packet_out.data", cfg_packet_out.data, rd_exp.data);
      end
      // Data packets in order and on their due cycle
      if (data_access_out)
      begin
         assert (exp_q.size() > 0)
         else
            fail_run($sformatf("Unexpected data packet at cycle %0d", cyc));
         e = exp_q.pop_front();
         assert (e.due == cyc)
         else
            fail_run($sformatf("Data packet at cycle %0d, expected at cycle %0d",
                               cyc, e.due));
         compare_hex("data_packet_out", data_packet_out, e.pkt);
      end
      else if (exp_q.size() > 0)
      begin
         assert (exp_q[0].due != cyc)
         else
            fail_run($sformatf("Data packet missing at cycle %0d", cyc));
      end
   endtask

   // ########################################
   // Reference model
   // ########################################

   task automatic model_cycle(input stim_row_t r, input emesh_packet_t p,
                              input logic [31:0] v);
      logic     hit;
      logic     tick;
      logic     take;
      exp_pkt_t e;
      hit  = (r.op != OP_NONE) && (r.id == `ETRACE_ID);
      // Every 2^rate-th trigger cycle
      tick = ((int'(m_div) % (1 << m_rate)) == 0);
      take = m_en && r.trig && (v != m_prev) && tick && !m_stop;
      if (take)
      begin
         e.pkt          = '0;
         e.pkt.write    = 1'b1;
         e.pkt.datamode = `ETRACE_DM64;
         e.pkt.dstaddr  = m_base + 32'(m_idx * 8);
         e.pkt.data     = v;
         e.pkt.srcaddr  = m_stamp;
         // Sample, push, pop, output
         e.due = cyc + 3;
         exp_q.push_back(e);
         if (m_idx == `ETRACE_DEPTH - 1)
         begin
            m_idx = 0;
            if (!m_loop)
               m_stop = 1'b1;
         end
         else
            m_idx++;
      end
      // Disabled clears everything
      if (!m_en)
      begin
         m_stamp = '0;
         m_div   = '0;
         m_idx   = 0;
         m_stop  = 1'b0;
      end
      else if (r.trig)
      begin
         m_stamp++;
         m_div++;
      end
      m_prev = v;
      // Response swaps the addresses
      rd_pending = hit && (r.op == OP_RD);
      if (rd_pending)
      begin
         rd_exp         = '0;
         rd_exp.write   = 1'b1;
         rd_exp.dstaddr = p.srcaddr;
         rd_exp.srcaddr = p.dstaddr;
         rd_exp.data    = r.exp_rd;
      end
      // Writes land on the clock edge
      if (hit && (r.op == OP_WR))
      begin
         if (r.idx == `ETRACE_CFG)
         begin
            m_en   = r.data[0];
            m_loop = r.data[1];
            m_rate = r.data[7:4];
         end
         else if (r.idx == `ETRACE_BASE)
            m_base = r.data;
      end
   endtask

   // ########################################
   // Stimulus
   // ########################################

   task automatic drive_row(input stim_row_t r);
      emesh_packet_t p;
      logic [31:0]   v;
      v = r.rnd ? $urandom() : r.vec;
      p = '0;
      if (r.op != OP_NONE)
      begin
         p.write    = (r.op == OP_WR);
         p.datamode = `ETRACE_DM32;
         p.dstaddr  = {r.id, `ETRACE_REGS, 10'h000, r.idx, 2'b00};
         p.data     = r.data;
         // Return address differs per request
         p.srcaddr  = 32'h81000000 + 32'(cyc);
      end
      cfg_access_in = (r.op != OP_NONE);
      cfg_packet_in = p;
      trace_trigger = r.trig;
      trace_vector  = v;
      model_cycle(r, p, v);
   endtask

   initial
   begin
      stim_row_t idle;
      int        iter;
      nreset        = 1'b0;
      trace_trigger = 1'b0;
      trace_vector  = '0;
      cfg_access_in = 1'b0;
      cfg_packet_in = '0;
      m_en          = 1'b0;
      m_loop        = 1'b0;
      m_rate        = '0;
      m_base        = '0;
      m_stamp       = '0;
      m_div         = '0;
      m_idx         = 0;
      m_stop        = 1'b0;
      m_prev        = '0;
      rd_pending    = 1'b0;
      cyc           = 0;
      idle          = '{OP_NONE, 12'h000, 4'h0, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 1};
      void'($urandom(32'h3f7e));
      load_table();
      // Reset held two cycles
      repeat (2) @(posedge trace_clk);
      @(negedge trace_clk);
      nreset = 1'b1;
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         for (int k = 0; k < stim[i].reps; k++)
         begin
            @(negedge trace_clk);
            cyc++;
            check_outputs();
            drive_row(stim[i]);
         end
      end
      // Drain the remaining packets
      iter = 0;
      while ((exp_q.size() > 0) && (iter < DRAIN_LIMIT))
      begin
         @(negedge trace_clk);
         cyc++;
         check_outputs();
         drive_row(idle);
         iter++;
      end
      if (exp_q.size() > 0)
         fail_run("Timeout waiting for data_access_out at end of run");
      else
      begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule
